//--- hdl/app_pkg.sv
/*
  Shared definitions for the USB CDC byte-stream application.
  Holds the command codes, controller states, widths, polynomials and stream types.
*/
package app_pkg;

   // Byte count and address width
   localparam int CNT_W = 24;

   // RAM address width carried in a memory request
   localparam int RAM_AW = 10;

   // Taps at bits 23, 22, 21 and 16
   localparam logic [23:0] LFSR_POLY = 24'hE10000;

   // CRC-32 (IEEE) generator
   localparam logic [31:0] CRC_POLY = 32'h04C11DB7;

   typedef enum logic [7:0] {
      CMD_NO         = 8'd0,
      CMD_IN         = 8'd1,
      CMD_OUT        = 8'd2,
      CMD_ADDR       = 8'd3,
      CMD_WAIT       = 8'd4,
      CMD_LFSR_WRITE = 8'd5,
      CMD_LFSR_READ  = 8'd6,
      CMD_RAM_READ   = 8'd8
   } cmd_e;

   typedef enum logic [3:0] {
      ST_LOOPBACK,
      ST_CMD0,
      ST_CMD1,
      ST_CMD2,
      ST_CMD3,
      ST_IN,
      ST_OUT,
      ST_READ0,
      ST_READ1,
      ST_READ2,
      ST_READ3,
      ST_READ_RAM
   } state_e;

   typedef struct packed {
      logic [7:0] data;
      logic       valid;
   } byte_stream_t;

   typedef struct packed {
      logic              en;
      logic              we;
      logic [RAM_AW-1:0] addr;
   } mem_req_t;

endpackage

//--- hdl/byte_pacer.sv
/*
  Byte pacer. Holds the one-entry out register and the wait setting,
  and blocks both streams for W cycles after each streamed data byte.
*/
`timescale 1ns/1ps

module byte_pacer #(
   parameter int WAIT_W = 8
) (
   input  logic                  clk_i,
   input  logic                  rstn,
   input  logic [7:0]            out_data_i,
   input  logic                  out_valid_i,
   output logic                  out_ready_o,
   input  logic                  in_ready_i,
   output logic [7:0]            in_data_o,
   output logic                  in_valid_o,
   output app_pkg::byte_stream_t out_byte_o,
   input  logic                  out_pop_i,
   input  app_pkg::byte_stream_t in_byte_i,
   output logic                  in_take_o,
   input  logic                  wait_set_i,
   input  logic                  pace_start_i
);

   app_pkg::byte_stream_t out_q;
   logic [WAIT_W-1:0]     wait_q;
   logic [WAIT_W-1:0]     gap_q;
   logic                  pacing;

   assign pacing      = |gap_q;
   assign out_ready_o = (~out_q.valid | out_pop_i) & ~pacing;
   assign out_byte_o  = out_q;

   assign in_data_o  = in_byte_i.data;
   assign in_valid_o = in_byte_i.valid & ~pacing;
   assign in_take_o  = in_valid_o & in_ready_i;

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         out_q  <= '0;
         wait_q <= '0;
         gap_q  <= '0;
      end else begin
         if (out_valid_i && out_ready_o) begin
            out_q.data  <= out_data_i;
            out_q.valid <= 1'b1;
         end else if (out_pop_i) begin
            out_q.valid <= 1'b0;
         end
         if (wait_set_i) begin
            wait_q <= WAIT_W'(out_q.data);
         end
         // Gap counts down to zero, restarted after each data byte
         if (pace_start_i) begin
            gap_q <= wait_q;
         end else if (pacing) begin
            gap_q <= gap_q - 1'b1;
         end
      end
   end

   // Only a full out register is popped
   a_pop_valid: assert property (@(posedge clk_i) disable iff (!rstn)
      out_pop_i |-> out_q.valid);

endmodule

//--- hdl/crc32_engine.sv
/*
  Running CRC-32 (IEEE) over a byte stream.
  Bytes are folded in LSB first; crc_o is the finished CRC, low byte sent first.
*/
`timescale 1ns/1ps

module crc32_engine (
   input  logic        clk_i,
   input  logic        rstn,
   input  logic        crc_init_i,
   input  logic        crc_upd_i,
   input  logic [7:0]  crc_data_i,
   output logic [31:0] crc_o
);

   logic [31:0] crc_q;

   function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         if (data[i] ^ c[31]) begin
            c = {c[30:0], 1'b0} ^ app_pkg::CRC_POLY;
         end else begin
            c = {c[30:0], 1'b0};
         end
      end
      return c;
   endfunction

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         crc_q <= '1;
      end else if (crc_init_i) begin
         crc_q <= '1;
      end else if (crc_upd_i) begin
         crc_q <= crc_byte(crc_q, crc_data_i);
      end
   end

   // Complement and bit-reverse into the reflected result
   always_comb begin
      for (int i = 0; i < 32; i++) begin
         crc_o[i] = ~crc_q[31-i];
      end
   end

   a_init_upd_excl: assert property (@(posedge clk_i) disable iff (!rstn)
      !(crc_init_i && crc_upd_i));

endmodule

//--- hdl/lfsr24.sv
/*
  24-bit LFSR source for the IN command.
  Seed loads one byte at a time; each step shifts in the inverted tap parity.
*/
`timescale 1ns/1ps

module lfsr24 (
   input  logic        clk_i,
   input  logic        rstn,
   input  logic        lfsr_load_i,
   input  logic [1:0]  load_idx_i,
   input  logic [7:0]  load_byte_i,
   input  logic        lfsr_step_i,
   output logic [23:0] lfsr_o
);

   logic [23:0] lfsr_q;
   logic        fb;

   // XNOR feedback keeps the all-zero state usable
   assign fb     = ~^(lfsr_q & app_pkg::LFSR_POLY);
   assign lfsr_o = lfsr_q;

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         lfsr_q <= '0;
      end else if (lfsr_load_i) begin
         case (load_idx_i)
            2'd0: lfsr_q[7:0]   <= load_byte_i;
            2'd1: lfsr_q[15:8]  <= load_byte_i;
            2'd2: lfsr_q[23:16] <= load_byte_i;
            default: lfsr_q     <= lfsr_q;
         endcase
      end else if (lfsr_step_i) begin
         lfsr_q <= {lfsr_q[22:0], fb};
      end
   end

endmodule

//--- hdl/byte_ram.sv
/*
  Single-port byte RAM with synchronous read and write.
  The request address wraps modulo RAM_DEPTH.
*/
`timescale 1ns/1ps

module byte_ram #(
   parameter int RAM_DEPTH = 1024
) (
   input  logic              clk_i,
   input  app_pkg::mem_req_t mem_req_i,
   input  logic [7:0]        wdata_i,
   output logic [7:0]        rdata_o
);

   localparam int AW = $clog2(RAM_DEPTH);

   logic [7:0]    mem [RAM_DEPTH];
   logic [AW-1:0] idx;

   assign idx = mem_req_i.addr[AW-1:0];

   always_ff @(posedge clk_i) begin
      if (mem_req_i.en) begin
         if (mem_req_i.we) begin
            mem[idx] <= wdata_i;
         end else begin
            rdata_o <= mem[idx];
         end
      end
   end

endmodule

//--- hdl/app_ctrl.sv
/*
  Command parser and mode FSM. Echoes bytes in loopback, parses
  0x00-framed commands and picks the source of the in stream.
*/
`timescale 1ns/1ps

module app_ctrl (
   input  logic                  clk_i,
   input  logic                  rstn,
   input  app_pkg::byte_stream_t out_byte_i,
   output logic                  out_pop_o,
   output app_pkg::byte_stream_t in_byte_o,
   input  logic                  in_take_i,
   output logic                  wait_set_o,
   output logic                  pace_start_o,
   output logic                  crc_init_o,
   output logic                  crc_upd_o,
   output logic [7:0]            crc_data_o,
   input  logic [31:0]           crc_i,
   output logic                  lfsr_load_o,
   output logic [1:0]            load_idx_o,
   output logic                  lfsr_step_o,
   input  logic [23:0]           lfsr_i,
   output app_pkg::mem_req_t     mem_req_o,
   input  logic [7:0]            rdata_i
);

   app_pkg::state_e            state_q, state_d;
   app_pkg::cmd_e              cmd_q, cmd_d;
   logic [app_pkg::CNT_W-1:0]  cnt_q, cnt_d;
   logic [app_pkg::CNT_W-1:0]  addr_q, addr_d;
   logic                       mem_vld_q, mem_vld_d;

   app_pkg::state_e nxt_state;
   app_pkg::state_e run_state;
   logic [1:0]      sub_idx;
   logic [31:0]     res_word;
   logic            has_count;

   // Argument or result byte index, and the following state in the sequence
   always_comb begin
      sub_idx   = 2'd0;
      nxt_state = app_pkg::ST_LOOPBACK;
      case (state_q)
         app_pkg::ST_CMD1:  nxt_state = app_pkg::ST_CMD2;
         app_pkg::ST_CMD2:  begin sub_idx = 2'd1; nxt_state = app_pkg::ST_CMD3; end
         app_pkg::ST_CMD3:  sub_idx = 2'd2;
         app_pkg::ST_READ0: nxt_state = app_pkg::ST_READ1;
         app_pkg::ST_READ1: begin sub_idx = 2'd1; nxt_state = app_pkg::ST_READ2; end
         app_pkg::ST_READ2: begin sub_idx = 2'd2; nxt_state = app_pkg::ST_READ3; end
         app_pkg::ST_READ3: sub_idx = 2'd3;
         default:           nxt_state = app_pkg::ST_LOOPBACK;
      endcase
   end

   assign has_count = (cmd_q == app_pkg::CMD_IN) || (cmd_q == app_pkg::CMD_OUT) ||
                      (cmd_q == app_pkg::CMD_RAM_READ);

   always_comb begin
      case (cmd_q)
         app_pkg::CMD_IN:       run_state = app_pkg::ST_IN;
         app_pkg::CMD_OUT:      run_state = app_pkg::ST_OUT;
         app_pkg::CMD_RAM_READ: run_state = app_pkg::ST_READ_RAM;
         default:               run_state = app_pkg::ST_LOOPBACK;
      endcase
   end

   // LFSR readback ends with a zero byte
   assign res_word = (cmd_q == app_pkg::CMD_LFSR_READ) ? {8'd0, lfsr_i} : crc_i;

   always_comb begin
      state_d   = state_q;
      cmd_d     = cmd_q;
      cnt_d     = cnt_q;
      addr_d    = addr_q;
      mem_vld_d = mem_vld_q;

      out_pop_o       = 1'b0;
      in_byte_o.data  = out_byte_i.data;
      in_byte_o.valid = 1'b0;
      wait_set_o      = 1'b0;
      pace_start_o    = 1'b0;
      crc_init_o      = 1'b0;
      crc_upd_o       = 1'b0;
      crc_data_o      = out_byte_i.data;
      lfsr_load_o     = 1'b0;
      load_idx_o      = sub_idx;
      lfsr_step_o     = 1'b0;
      mem_req_o.en    = 1'b0;
      mem_req_o.we    = 1'b0;
      mem_req_o.addr  = addr_q[app_pkg::RAM_AW-1:0];

      case (state_q)
         app_pkg::ST_LOOPBACK: begin
            if (out_byte_i.valid) begin
               if (out_byte_i.data == 8'h00) begin
                  out_pop_o = 1'b1;
                  state_d   = app_pkg::ST_CMD0;
               end else begin
                  // Echo and store at the running address
                  in_byte_o.valid = 1'b1;
                  out_pop_o       = in_take_i;
                  if (in_take_i) begin
                     mem_req_o.en = 1'b1;
                     mem_req_o.we = 1'b1;
                     addr_d       = addr_q + 1'b1;
                  end
               end
            end
         end
         app_pkg::ST_CMD0: begin
            out_pop_o = out_byte_i.valid;
            if (out_byte_i.valid) begin
               cmd_d   = app_pkg::cmd_e'(out_byte_i.data);
               state_d = app_pkg::ST_CMD1;
            end
         end
         app_pkg::ST_CMD1, app_pkg::ST_CMD2, app_pkg::ST_CMD3: begin
            if (has_count || cmd_q == app_pkg::CMD_ADDR || cmd_q == app_pkg::CMD_LFSR_WRITE) begin
               out_pop_o = out_byte_i.valid;
               if (out_byte_i.valid) begin
                  if (has_count) begin
                     cnt_d[sub_idx*8 +: 8] = out_byte_i.data;
                  end else if (cmd_q == app_pkg::CMD_ADDR) begin
                     addr_d[sub_idx*8 +: 8] = out_byte_i.data;
                  end else begin
                     lfsr_load_o = 1'b1;
                  end
                  if (state_q == app_pkg::ST_CMD3) begin
                     state_d    = run_state;
                     crc_init_o = (cmd_q == app_pkg::CMD_IN) || (cmd_q == app_pkg::CMD_OUT);
                  end else begin
                     state_d = nxt_state;
                  end
               end
            end else if (cmd_q == app_pkg::CMD_WAIT && state_q == app_pkg::ST_CMD1) begin
               out_pop_o = out_byte_i.valid;
               if (out_byte_i.valid) begin
                  wait_set_o = 1'b1;
                  state_d    = app_pkg::ST_LOOPBACK;
               end
            end else if (cmd_q == app_pkg::CMD_LFSR_READ) begin
               state_d = app_pkg::ST_READ0;
            end else begin
               state_d = app_pkg::ST_LOOPBACK;
            end
         end
         app_pkg::ST_IN: begin
            in_byte_o.data  = lfsr_i[7:0];
            in_byte_o.valid = 1'b1;
            if (in_take_i) begin
               crc_upd_o    = 1'b1;
               crc_data_o   = lfsr_i[7:0];
               lfsr_step_o  = 1'b1;
               pace_start_o = 1'b1;
               if (cnt_q == '0) begin
                  state_d = app_pkg::ST_READ0;
               end else begin
                  cnt_d = cnt_q - 1'b1;
               end
            end
         end
         app_pkg::ST_OUT: begin
            out_pop_o = out_byte_i.valid;
            if (out_byte_i.valid) begin
               crc_upd_o    = 1'b1;
               pace_start_o = 1'b1;
               if (cnt_q == '0) begin
                  state_d = app_pkg::ST_READ0;
               end else begin
                  cnt_d = cnt_q - 1'b1;
               end
            end
         end
         app_pkg::ST_READ0, app_pkg::ST_READ1, app_pkg::ST_READ2, app_pkg::ST_READ3: begin
            in_byte_o.data  = res_word[sub_idx*8 +: 8];
            in_byte_o.valid = 1'b1;
            if (in_take_i) begin
               state_d = nxt_state;
            end
         end
         app_pkg::ST_READ_RAM: begin
            // mem_vld_q marks read data waiting on rdata_i
            if (!mem_vld_q) begin
               mem_req_o.en = 1'b1;
               mem_vld_d    = 1'b1;
               addr_d       = addr_q + 1'b1;
            end
            in_byte_o.data  = rdata_i;
            in_byte_o.valid = mem_vld_q;
            if (in_take_i && mem_vld_q) begin
               pace_start_o = 1'b1;
               if (cnt_q == '0) begin
                  mem_vld_d = 1'b0;
                  addr_d    = '0;
                  state_d   = app_pkg::ST_LOOPBACK;
               end else begin
                  cnt_d        = cnt_q - 1'b1;
                  mem_req_o.en = 1'b1;
                  addr_d       = addr_q + 1'b1;
               end
            end
         end
         default: state_d = app_pkg::ST_LOOPBACK;
      endcase
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         state_q   <= app_pkg::ST_LOOPBACK;
         cmd_q     <= app_pkg::CMD_NO;
         cnt_q     <= '0;
         addr_q    <= '0;
         mem_vld_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         cmd_q     <= cmd_d;
         cnt_q     <= cnt_d;
         addr_q    <= addr_d;
         mem_vld_q <= mem_vld_d;
      end
   end

   a_in_hold: assert property (@(posedge clk_i) disable iff (!rstn)
      in_byte_o.valid && !in_take_i |=> $stable(in_byte_o.data));

endmodule

//--- hdl/usb_app.sv
/*
  USB CDC byte-stream application top level.
  Synchronizes reset and connects pacer, controller, CRC, LFSR and RAM.
*/
`timescale 1ns/1ps

module usb_app #(
   parameter int RAM_DEPTH = 1024,
   parameter int WAIT_W    = 8
) (
   input  logic       clk_i,
   input  logic       rstn_i,
   input  logic [7:0] out_data_i,
   input  logic       out_valid_i,
   output logic       out_ready_o,
   output logic [7:0] in_data_o,
   output logic       in_valid_o,
   input  logic       in_ready_i
);

   logic                  rst_meta;
   logic                  rstn;
   app_pkg::byte_stream_t out_byte;
   app_pkg::byte_stream_t in_byte;
   logic                  out_pop;
   logic                  in_take;
   logic                  wait_set;
   logic                  pace_start;
   logic                  crc_init;
   logic                  crc_upd;
   logic [7:0]            crc_data;
   logic [31:0]           crc;
   logic                  lfsr_load;
   logic [1:0]            load_idx;
   logic                  lfsr_step;
   logic [23:0]           lfsr;
   app_pkg::mem_req_t     mem_req;
   logic [7:0]            rdata;

   initial begin
      assert ((RAM_DEPTH & (RAM_DEPTH - 1)) == 0 && RAM_DEPTH <= (1 << app_pkg::RAM_AW) &&
              app_pkg::RAM_AW <= app_pkg::CNT_W)
         else $fatal(1, "RAM_DEPTH must be a power of two not above 2**RAM_AW");
   end

   // Async assert, sync release
   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         rst_meta <= 1'b0;
         rstn     <= 1'b0;
      end else begin
         rst_meta <= 1'b1;
         rstn     <= rst_meta;
      end
   end

   byte_pacer #(.WAIT_W(WAIT_W)) u_pacer (
      .clk_i, .rstn,
      .out_data_i, .out_valid_i, .out_ready_o,
      .in_ready_i, .in_data_o, .in_valid_o,
      .out_byte_o(out_byte), .out_pop_i(out_pop),
      .in_byte_i(in_byte), .in_take_o(in_take),
      .wait_set_i(wait_set), .pace_start_i(pace_start)
   );

   app_ctrl u_ctrl (
      .clk_i, .rstn,
      .out_byte_i(out_byte), .out_pop_o(out_pop),
      .in_byte_o(in_byte), .in_take_i(in_take),
      .wait_set_o(wait_set), .pace_start_o(pace_start),
      .crc_init_o(crc_init), .crc_upd_o(crc_upd), .crc_data_o(crc_data), .crc_i(crc),
      .lfsr_load_o(lfsr_load), .load_idx_o(load_idx), .lfsr_step_o(lfsr_step), .lfsr_i(lfsr),
      .mem_req_o(mem_req), .rdata_i(rdata)
   );

   crc32_engine u_crc (
      .clk_i, .rstn,
      .crc_init_i(crc_init), .crc_upd_i(crc_upd), .crc_data_i(crc_data), .crc_o(crc)
   );

   lfsr24 u_lfsr (
      .clk_i, .rstn,
      .lfsr_load_i(lfsr_load), .load_idx_i(load_idx), .load_byte_i(out_byte.data),
      .lfsr_step_i(lfsr_step), .lfsr_o(lfsr)
   );

   byte_ram #(.RAM_DEPTH(RAM_DEPTH)) u_ram (
      .clk_i,
      .mem_req_i(mem_req), .wdata_i(out_byte.data), .rdata_o(rdata)
   );

endmodule

//--- dv/tb_ref.svh
/*
  Reference models for the usb_app testbench.
  Standard reflected CRC-32 and the 24-bit LFSR step rule.
*/
`ifndef TB_REF_SVH
`define TB_REF_SVH

// CRC-32 (IEEE) of a byte sequence, computed LSB first with the reflected generator
function automatic logic [31:0] crc32_ref(input logic [7:0] bytes[$]);
   logic [31:0] rpoly;
   logic [31:0] crc;
   for (int i = 0; i < 32; i++) begin
      rpoly[i] = app_pkg::CRC_POLY[31-i];
   end
   crc = '1;
   foreach (bytes[k]) begin
      crc = crc ^ {24'd0, bytes[k]};
      for (int b = 0; b < 8; b++) begin
         if (crc[0]) begin
            crc = (crc >> 1) ^ rpoly;
         end else begin
            crc = crc >> 1;
         end
      end
   end
   return ~crc;
endfunction

// Shift left and insert the inverted parity of the tapped bits
function automatic logic [23:0] lfsr_next_ref(input logic [23:0] s);
   logic par;
   par = 1'b0;
   for (int i = 0; i < 24; i++) begin
      if (app_pkg::LFSR_POLY[i]) begin
         par = par ^ s[i];
      end
   end
   return {s[22:0], ~par};
endfunction

`endif

//--- dv/tb_usb_app.sv
/*
  Testbench for usb_app. Drives the out stream with loopback data and
  command frames, and checks the in stream against reference models.
*/
`timescale 1ns/1ps

module tb_usb_app;

   localparam int LOOP_BYTES  = 50;
   localparam int IN_BYTES    = 32;
   localparam int OUT_BYTES   = 20;
   localparam int RAM_BYTES   = 16;
   localparam int PACED_BYTES = 8;
   localparam int WAIT_CYCLES = 5;
   // About 250 transfers and frame bytes, each well under 10 cycles even with
   // back-pressure or pacing, so roughly 3000 cycles; the limit leaves wide margin
   localparam int TIMEOUT_CYCLES = 20000;

   typedef struct packed {
      logic [7:0] data;
      logic       paced;
   } exp_t;

   logic       clk_i = 1'b0;
   logic       rstn_i;
   logic [7:0] out_data_i;
   logic       out_valid_i;
   logic       out_ready_o;
   logic [7:0] in_data_o;
   logic       in_valid_o;
   logic       in_ready_i = 1'b1;

   logic        bp_en = 1'b0;
   exp_t        exp_q[$];
   logic [23:0] lfsr_model;
   int          cycle = 0;
   int          errors = 0;
   int          checks = 0;
   int          last_paced = 0;
   logic        paced_seen = 1'b0;

   `include "tb_ref.svh"

   usb_app #(.RAM_DEPTH(1024), .WAIT_W(8)) DUT (
      .clk_i, .rstn_i,
      .out_data_i, .out_valid_i, .out_ready_o,
      .in_data_o, .in_valid_o, .in_ready_i
   );

   always #10 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle <= cycle + 1;
      if (cycle >= TIMEOUT_CYCLES) begin
         $display("Timeout: run stopped after %0d cycles, %0d bytes never arrived",
                  cycle, exp_q.size());
         $display("Errors found");
         $finish;
      end
   end

   // Random back-pressure, decided at the edge and driven just after it
   task automatic drive_backpressure();
      logic hold_low;
      forever begin
         @(posedge clk_i);
         hold_low = bp_en && ($urandom % 4 == 0);
         #2;
         in_ready_i = !hold_low;
      end
   endtask

   task automatic check_val(input string name, input logic [7:0] got,
                            input logic [7:0] expected);
      checks++;
      if (got !== expected) begin
         $display("[ERROR] %0t %s: got %02h, expected %02h", $time, name, got, expected);
         errors++;
      end
   endtask

   always @(posedge clk_i) begin : monitor
      exp_t item;
      if (in_valid_o && in_ready_i) begin
         if (exp_q.size() == 0) begin
            $display("%0t: unexpected byte %02h on the in stream", $time, in_data_o);
            errors++;
         end else begin
            item = exp_q.pop_front();
            check_val("in_data_o", in_data_o, item.data);
            if (item.paced) begin
               if (paced_seen && (cycle - last_paced) < WAIT_CYCLES + 1) begin
                  $display("%0t: paced bytes only %0d cycles apart, wait setting is %0d",
                           $time, cycle - last_paced, WAIT_CYCLES);
                  errors++;
               end
               paced_seen = 1'b1;
               last_paced = cycle;
            end
         end
      end
   end

   function automatic logic [7:0] rand_nonzero();
      return 8'($urandom % 255) + 8'd1;
   endfunction

   task automatic expect_byte(input logic [7:0] b, input logic paced);
      exp_t item;
      item.data  = b;
      item.paced = paced;
      exp_q.push_back(item);
   endtask

   // Result word goes out low byte first
   task automatic expect_word(input logic [31:0] w);
      for (int i = 0; i < 4; i++) begin
         expect_byte(w[i*8 +: 8], 1'b0);
      end
   endtask

   // Expected IN stream from the LFSR model, followed by its CRC
   task automatic expect_lfsr_stream(input int count, input logic paced);
      logic [7:0] bytes[$];
      for (int i = 0; i < count; i++) begin
         bytes.push_back(lfsr_model[7:0]);
         expect_byte(lfsr_model[7:0], paced);
         lfsr_model = lfsr_next_ref(lfsr_model);
      end
      expect_word(crc32_ref(bytes));
   endtask

   // Called and returns 2 ns after a rising edge
   task automatic send_byte(input logic [7:0] b);
      out_data_i  = b;
      out_valid_i = 1'b1;
      @(posedge clk_i);
      while (!out_ready_o) begin
         @(posedge clk_i);
      end
      #2;
      out_valid_i = 1'b0;
   endtask

   task automatic send_cmd(input app_pkg::cmd_e code, input logic [23:0] arg, input int nargs);
      send_byte(8'h00);
      send_byte(code);
      for (int i = 0; i < nargs; i++) begin
         send_byte(arg[i*8 +: 8]);
      end
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) begin
         @(posedge clk_i);
         #2;
      end
   endtask

   initial begin
      logic [7:0]  bytes[$];
      logic [7:0]  b;
      logic [23:0] seed;
      void'($urandom(65125));
      fork
         drive_backpressure();
      join_none
      out_data_i  = 8'h00;
      out_valid_i = 1'b0;
      rstn_i      = 1'b0;
      repeat (5) @(posedge clk_i);
      #2;
      rstn_i = 1'b1;
      // Let the reset synchronizer release
      repeat (3) @(posedge clk_i);
      #2;

      // Idle outputs after reset
      check_val("out_ready_o", {7'd0, out_ready_o}, 8'd1);
      check_val("in_valid_o", {7'd0, in_valid_o}, 8'd0);

      // Loopback echo under back-pressure
      bp_en = 1'b1;
      for (int i = 0; i < LOOP_BYTES; i++) begin
         b = rand_nonzero();
         expect_byte(b, 1'b0);
         send_byte(b);
      end
      wait_drain();

      // Seed write and readback
      seed = 24'($urandom);
      lfsr_model = seed;
      send_cmd(app_pkg::CMD_LFSR_WRITE, seed, 3);
      expect_word({8'd0, seed});
      send_cmd(app_pkg::CMD_LFSR_READ, 24'd0, 0);
      wait_drain();

      // IN stream from the written seed
      expect_lfsr_stream(IN_BYTES, 1'b0);
      send_cmd(app_pkg::CMD_IN, 24'(IN_BYTES - 1), 3);
      wait_drain();

      // OUT sink and its CRC
      bytes.delete();
      for (int i = 0; i < OUT_BYTES; i++) begin
         bytes.push_back(8'($urandom));
      end
      expect_word(crc32_ref(bytes));
      send_cmd(app_pkg::CMD_OUT, 24'(OUT_BYTES - 1), 3);
      foreach (bytes[i]) begin
         send_byte(bytes[i]);
      end
      wait_drain();

      // Loopback into RAM from address 0, then read it back
      send_cmd(app_pkg::CMD_ADDR, 24'd0, 3);
      bytes.delete();
      for (int i = 0; i < RAM_BYTES; i++) begin
         b = rand_nonzero();
         bytes.push_back(b);
         expect_byte(b, 1'b0);
         send_byte(b);
      end
      wait_drain();
      foreach (bytes[i]) begin
         expect_byte(bytes[i], 1'b0);
      end
      send_cmd(app_pkg::CMD_ADDR, 24'd0, 3);
      send_cmd(app_pkg::CMD_RAM_READ, 24'(RAM_BYTES - 1), 3);
      wait_drain();

      // Paced IN stream with in_ready_i held high
      bp_en = 1'b0;
      send_cmd(app_pkg::CMD_WAIT, 24'(WAIT_CYCLES), 1);
      expect_lfsr_stream(PACED_BYTES, 1'b1);
      send_cmd(app_pkg::CMD_IN, 24'(PACED_BYTES - 1), 3);
      wait_drain();

      repeat (4) @(posedge clk_i);
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- project.f
+incdir+dv
hdl/app_pkg.sv
hdl/byte_pacer.sv
hdl/crc32_engine.sv
hdl/lfsr24.sv
hdl/byte_ram.sv
hdl/app_ctrl.sv
hdl/usb_app.sv
dv/tb_usb_app.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the usb_app testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   -f project.f \
   --top-module tb_usb_app \
   -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Errors found" sim.log; then
   echo "Simulation FAILED"
   exit 1
fi
echo "Simulation passed"
